/* dv/color_mapper_checker.sv */
/*
  Reference model and assertions for color_mapper_top, attached by bind.
  Expected colors come from the package palettes and the top-level inputs
  sampled two clocks earlier. Checks start on the fourth clock edge.
  fail_count counts failed assertions.
*/
`timescale 1ns/1ps
`default_nettype none

module color_mapper_checker #(
    parameter int NUM_WALLS = 12,
    parameter int SHOE_WALL = 0
) (
    input logic                         Clk,
    input logic                         rst_n,
    input logic                         pixel_valid,
    input logic                         fire,
    input color_mapper_pkg::player_px_t player1,
    input color_mapper_pkg::player_px_t player2,
    input color_mapper_pkg::bomb_px_t   bomb1,
    input color_mapper_pkg::bomb_px_t   bomb2,
    input logic [NUM_WALLS-1:0]         wall_hit,
    input logic [NUM_WALLS-1:0]         bombed_by_p1,
    input logic [NUM_WALLS-1:0]         bombed_by_p2,
    input logic                         shoe_hit,
    input logic [1:0]                   shoe_held,
    input color_mapper_pkg::color_idx_t shoe_idx,
    input color_mapper_pkg::color_idx_t box_idx,
    input color_mapper_pkg::color_idx_t bg_idx,
    input color_mapper_pkg::rgb_t       vga_color,
    input logic                         vga_valid
);

    import color_mapper_pkg::*;

    int unsigned fail_count = 0;
    logic [1:0]  warm_cnt = '0;
    logic [23:0] bg_color;
    logic [23:0] expected_color;
    logic        idle;
    logic        wall_found;

    function automatic color_idx_t facing_frame(input player_px_t p);
        if (p.facing == FACE_LEFT)
            return p.idx_left;
        else if (p.facing == FACE_RIGHT)
            return p.idx_right;
        else if (p.facing == FACE_DOWN)
            return p.idx_down;
        return p.idx_forward;
    endfunction

    // see-through or cleared sprites show the floor
    function automatic logic [23:0] keyed_or_bg(input logic [23:0] entry,
                                                input logic [23:0] key,
                                                input logic clear,
                                                input logic [23:0] bg);
        if (clear || (entry == key))
            return bg;
        return entry;
    endfunction

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    always_comb
    begin
        bg_color       = BACKGROUND_PAL[bg_idx];
        idle           = !(fire || player1.hit || player2.hit || bomb1.hit || bomb2.hit
                           || (|wall_hit));
        expected_color = bg_color;
        wall_found     = 1'b0;
        if (fire)
            expected_color = FIRE_COLOR;
        else if (player1.hit)
            expected_color = keyed_or_bg(PLAYER1_PAL[facing_frame(player1)],
                                         TRANSPARENT_MAGENTA, player1.dead, bg_color);
        else if (player2.hit)
            expected_color = keyed_or_bg(PLAYER2_PAL[facing_frame(player2)],
                                         TRANSPARENT_MAGENTA, player2.dead, bg_color);
        else if (bomb1.hit)
            expected_color = keyed_or_bg(BOMB1_PAL[bomb1.idx], TRANSPARENT_BLACK, 1'b0, bg_color);
        else if (bomb2.hit)
            expected_color = keyed_or_bg(BOMB2_PAL[bomb2.idx], TRANSPARENT_BLACK, 1'b0, bg_color);
        else
        begin
            for (int i = 0; i < NUM_WALLS; i++)
            begin
                if (wall_hit[i] && !wall_found)
                begin
                    wall_found = 1'b1;
                    if (!bombed_by_p1[i] && !bombed_by_p2[i])
                        expected_color = BOX_PAL[box_idx];
                    else if ((i == SHOE_WALL) && shoe_hit && (shoe_held == 2'b00))
                        expected_color = keyed_or_bg(SHOE_PAL[shoe_idx], TRANSPARENT_MAGENTA,
                                                     1'b0, bg_color);
                end
            end
        end
    end

    always @(posedge Clk)
    begin
        if (warm_cnt != 2'd3)
            warm_cnt <= warm_cnt + 2'd1;
    end

    // ----------------------------------------
    // assertions
    // ----------------------------------------
    valid_latency: assert property (@(posedge Clk) disable iff (warm_cnt != 2'd3)
        vga_valid == ($past(rst_n, 1) && $past(rst_n, 2) && $past(pixel_valid, 2)))
    else
    begin
        $error("ERROR %0t: vga_valid does not follow pixel_valid two cycles later", $time);
        fail_count++;
    end

    fire_wins: assert property (@(posedge Clk) disable iff (warm_cnt != 2'd3)
        (vga_valid && $past(fire, 2)) |-> (vga_color == FIRE_COLOR))
    else
    begin
        $error("ERROR %0t: fire pixel is not drawn in the fire color", $time);
        fail_count++;
    end

    floor_only: assert property (@(posedge Clk) disable iff (warm_cnt != 2'd3)
        (vga_valid && $past(idle, 2)) |-> (vga_color == $past(bg_color, 2)))
    else
    begin
        $error("ERROR %0t: empty pixel is not drawn in its background color", $time);
        fail_count++;
    end

    layer_color: assert property (@(posedge Clk) disable iff (warm_cnt != 2'd3)
        vga_valid |-> (vga_color == $past(expected_color, 2)))
    else
    begin
        $error("ERROR %0t: vga_color differs from the expected layer color", $time);
        fail_count++;
    end

endmodule

bind color_mapper_top color_mapper_checker #(
    .NUM_WALLS(NUM_WALLS),
    .SHOE_WALL(SHOE_WALL)
) checker_inst (.*);

`default_nettype wire

/* dv/color_mapper_tb.sv */
/*
  Testbench for color_mapper_top with 4000 random pixels.
  Layer hits are biased so each layer ends up on top often, and palette
  index 0 (the key entry) is favored. Checking lives in the bound checker.
*/
`timescale 1ns/1ps
`default_nettype none

module color_mapper_tb;

    import color_mapper_pkg::*;

    localparam int NUM_WALLS  = 12;
    localparam int SHOE_WALL  = 0;
    localparam int NUM_PIXELS = 4000;
    localparam int CLK_PERIOD = 4;

    logic                 Clk;
    logic                 rst_n;
    logic                 pixel_valid;
    logic                 fire;
    player_px_t           player1;
    player_px_t           player2;
    bomb_px_t             bomb1;
    bomb_px_t             bomb2;
    logic [NUM_WALLS-1:0] wall_hit;
    logic [NUM_WALLS-1:0] bombed_by_p1;
    logic [NUM_WALLS-1:0] bombed_by_p2;
    logic                 shoe_hit;
    logic [1:0]           shoe_held;
    color_idx_t           shoe_idx;
    color_idx_t           box_idx;
    color_idx_t           bg_idx;
    rgb_t                 vga_color;
    logic                 vga_valid;

    color_mapper_top #(
        .NUM_WALLS(NUM_WALLS),
        .SHOE_WALL(SHOE_WALL)
    ) color_mapper_top_inst (.*);

    always #(CLK_PERIOD / 2) Clk = ~Clk;

    // key entries sit at index 0
    function automatic color_idx_t pick_idx();
        if ($urandom_range(0, 3) == 0)
            return 4'd0;
        return color_idx_t'($urandom_range(0, 15));
    endfunction

    // rank 0 fire, 1..4 sprites, 5 walls; top 6 means nothing hit
    function automatic logic layer_hit(input int unsigned top, input int unsigned rank);
        return (rank == top) || ((rank > top) && ($urandom_range(0, 1) == 1));
    endfunction

    function automatic player_px_t random_player(input logic hit);
        player_px_t p;
        p.hit         = hit;
        p.dead        = ($urandom_range(0, 3) == 0);
        p.facing      = facing_t'($urandom_range(0, 3));
        p.idx_left    = pick_idx();
        p.idx_right   = pick_idx();
        p.idx_down    = pick_idx();
        p.idx_forward = pick_idx();
        return p;
    endfunction

    task automatic clear_inputs();
        rst_n        = 1'b0;
        pixel_valid  = 1'b0;
        fire         = 1'b0;
        player1      = '0;
        player2      = '0;
        bomb1        = '0;
        bomb2        = '0;
        wall_hit     = '0;
        bombed_by_p1 = '0;
        bombed_by_p2 = '0;
        shoe_hit     = 1'b0;
        shoe_held    = 2'b00;
        shoe_idx     = '0;
        box_idx      = '0;
        bg_idx       = '0;
    endtask

    task automatic drive_pixel();
        int unsigned top;
        int unsigned wall;
        top          = $urandom_range(0, 6);
        pixel_valid  = ($urandom_range(0, 7) != 0);
        fire         = (top == 0);
        player1      = random_player(layer_hit(top, 1));
        player2      = random_player(layer_hit(top, 2));
        bomb1        = '{hit: layer_hit(top, 3), idx: pick_idx()};
        bomb2        = '{hit: layer_hit(top, 4), idx: pick_idx()};
        wall_hit     = '0;
        if (layer_hit(top, 5))
        begin
            // a third of wall hits land on the shoe wall
            wall = ($urandom_range(0, 2) == 0) ? SHOE_WALL : $urandom_range(0, NUM_WALLS - 1);
            wall_hit[wall] = 1'b1;
            if ($urandom_range(0, 3) == 0)
                wall_hit[$urandom_range(0, NUM_WALLS - 1)] = 1'b1;
        end
        bombed_by_p1 = NUM_WALLS'($urandom);
        bombed_by_p2 = NUM_WALLS'($urandom);
        shoe_hit     = ($urandom_range(0, 1) == 1);
        shoe_held    = ($urandom_range(0, 1) == 0) ? 2'b00 : 2'($urandom_range(1, 3));
        shoe_idx     = pick_idx();
        box_idx      = pick_idx();
        bg_idx       = pick_idx();
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial
    begin
        void'($urandom(82));
        Clk = 1'b0;
        clear_inputs();
        repeat (4) @(negedge Clk);
        rst_n = 1'b1;
        for (int n = 0; n < NUM_PIXELS; n++)
        begin
            drive_pixel();
            @(negedge Clk);
        end
        pixel_valid = 1'b0;
        // drain the two pixels in flight
        repeat (4) @(negedge Clk);
        if (color_mapper_top_inst.checker_inst.fail_count == 0)
        begin
            $display("TEST PASS");
            $finish;
        end
        else
        begin
            $display("TEST FAIL");
            $fatal(1, "color checker reported assertion failures");
        end
    end

    // stop at the first failed assertion
    initial
    begin
        wait (color_mapper_top_inst.checker_inst.fail_count != 0);
        $display("TEST FAIL");
        $fatal(1, "a color checker assertion failed");
    end

    initial
    begin
        #((NUM_PIXELS + 100) * CLK_PERIOD);
        $display("TEST FAIL");
        $fatal(1, "test timed out before all pixels were driven and checked");
    end

endmodule

`default_nettype wire

/* hdl/color_mapper_pkg.sv */
/*
  Shared types and constants for the arena pixel color mapper.
  Palettes are fixed 16-entry tables of 24-bit RGB words, entry 0 first.
  Player and shoe sprites key on magenta, bomb sprites on black.
  Box and background palettes have no transparent entry.
*/
`default_nettype none

package color_mapper_pkg;

    // ----------------------------------------
    // basic color types
    // ----------------------------------------
    typedef logic [3:0] color_idx_t;

    typedef logic [23:0] palette_t [16];

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // raw word for key compares, channels for the VGA side
    typedef union packed {
        logic [23:0] raw;
        rgb_t        rgb;
    } color_u;

    typedef enum logic [2:0] {
        PAL_PLAYER1,
        PAL_PLAYER2,
        PAL_SHOE,
        PAL_BOX,
        PAL_BOMB1,
        PAL_BOMB2,
        PAL_BACKGROUND
    } pal_sel_t;

    typedef enum logic [1:0] {
        FACE_LEFT,
        FACE_RIGHT,
        FACE_DOWN,
        FACE_FORWARD
    } facing_t;

    typedef enum logic [1:0] {
        WALL_NONE,
        WALL_BOX,
        WALL_OPEN,
        WALL_SHOE
    } wall_state_t;

    // ----------------------------------------
    // per-pixel inputs and pipeline payload
    // ----------------------------------------
    typedef struct packed {
        logic       hit;
        logic       dead;
        facing_t    facing;
        color_idx_t idx_left;
        color_idx_t idx_right;
        color_idx_t idx_down;
        color_idx_t idx_forward;
    } player_px_t;

    typedef struct packed {
        logic       hit;
        color_idx_t idx;
    } bomb_px_t;

    typedef struct packed {
        logic hit;
        logic opaque;
        rgb_t color;
    } layer_t;

    typedef struct packed {
        logic        valid;
        logic        fire;
        layer_t      p1;
        layer_t      p2;
        layer_t      b1;
        layer_t      b2;
        wall_state_t wall;
        layer_t      box;
        layer_t      shoe;
        layer_t      bg;
    } stage_t;

    // ----------------------------------------
    // key colors
    // ----------------------------------------
    localparam logic [23:0] TRANSPARENT_MAGENTA = 24'hff00ff;
    localparam logic [23:0] TRANSPARENT_BLACK   = 24'h000000;
    localparam logic [23:0] FIRE_COLOR          = 24'hff0000;

    // ----------------------------------------
    // palettes
    // ----------------------------------------
    localparam palette_t PLAYER1_PAL = '{
        24'hff00ff, 24'hffc6c6, 24'he50000, 24'hf40000,
        24'h000000, 24'hffffff, 24'h5f341e, 24'h814527,
        24'h318d95, 24'h00e9ff, 24'hffa5a5, 24'hffdada,
        24'h424242, 24'h303030, 24'ha70d00, 24'hc66b42};

    localparam palette_t PLAYER2_PAL = '{
        24'hff00ff, 24'h6b6b6b, 24'ha3a3a3, 24'hffffff,
        24'h8c4a29, 24'hed9a6b, 24'h5f341e, 24'hffcaac,
        24'h454545, 24'h505050, 24'hffb286, 24'hababab,
        24'h434343, 24'hdedede, 24'h535353, 24'h767676};

    localparam palette_t SHOE_PAL = '{
        24'hff00ff, 24'hffffff, 24'h424242, 24'h6b6b6b,
        24'hd6d6d6, 24'h949494, 24'hb50000, 24'hff4a4a,
        24'hff6300, 24'hff9400, 24'hfff7e7, 24'h000000,
        24'h635a63, 24'hd67b18, 24'hcec6ce, 24'hd67b18};

    localparam palette_t BOX_PAL = '{
        24'hce8600, 24'h845100, 24'h633c00, 24'h5a3400,
        24'hf7b639, 24'hffbe42, 24'had7108, 24'hc68e18,
        24'h9c6500, 24'hbd8618, 24'hd69621, 24'hffcb63,
        24'hffd373, 24'h6b4500, 24'h8c5900, 24'h946500};

    localparam palette_t BOMB1_PAL = '{
        24'h000000, 24'h278dbd, 24'h16c8ff, 24'h0057c1,
        24'h1891f5, 24'h57f9ff, 24'h6ffeff, 24'heffffc,
        24'h008bf0, 24'h019dfa, 24'h0088f6, 24'h0bbaff,
        24'h6bd3ee, 24'h01c6fc, 24'h0179e8, 24'h12a3e4};

    localparam palette_t BOMB2_PAL = '{
        24'h000000, 24'h081018, 24'hffffff, 24'h10285a,
        24'h294163, 24'h29456b, 24'h9ca6bd, 24'hc6d3de,
        24'hdee3e7, 24'h637994, 24'h182439, 24'h298ac6,
        24'h101429, 24'h101c39, 24'hd6f3ff, 24'heff3ff};

    localparam palette_t BACKGROUND_PAL = '{
        24'h3e4049, 24'h30333a, 24'h3a2a4f, 24'h15192a,
        24'h1f1724, 24'h261a28, 24'h322638, 24'h3a2d3e,
        24'h8ea8b3, 24'h2f2231, 24'h251829, 24'h2f3036,
        24'h332437, 24'h312331, 24'h373743, 24'h3c303e};

endpackage

`default_nettype wire

/* hdl/color_mapper_top.sv */
/*
  Pixel color mapper for the two-player arena.
  Accepts one pixel per cycle with no back-pressure; the color comes out
  two cycles later with vga_valid. vga_valid stays low for two cycles
  after reset. Walls are numbered from 0; SHOE_WALL hides the shoe.
*/
`timescale 1ns/1ps
`default_nettype none

module color_mapper_top #(
    parameter int NUM_WALLS = 12,
    parameter int SHOE_WALL = 0
) (
    input  logic                         Clk,
    input  logic                         rst_n,
    input  logic                         pixel_valid,
    input  logic                         fire,
    input  color_mapper_pkg::player_px_t player1,
    input  color_mapper_pkg::player_px_t player2,
    input  color_mapper_pkg::bomb_px_t   bomb1,
    input  color_mapper_pkg::bomb_px_t   bomb2,
    input  logic [NUM_WALLS-1:0]         wall_hit,
    input  logic [NUM_WALLS-1:0]         bombed_by_p1,
    input  logic [NUM_WALLS-1:0]         bombed_by_p2,
    input  logic                         shoe_hit,
    input  logic [1:0]                   shoe_held,
    input  color_mapper_pkg::color_idx_t shoe_idx,
    input  color_mapper_pkg::color_idx_t box_idx,
    input  color_mapper_pkg::color_idx_t bg_idx,
    output color_mapper_pkg::rgb_t       vga_color,
    output logic                         vga_valid
);

    import color_mapper_pkg::*;

    stage_t stage;

    sprite_stage #(
        .NUM_WALLS(NUM_WALLS),
        .SHOE_WALL(SHOE_WALL)
    ) sprite_stage_inst (
        .Clk(Clk),
        .rst_n(rst_n),
        .pixel_valid(pixel_valid),
        .fire(fire),
        .player1(player1),
        .player2(player2),
        .bomb1(bomb1),
        .bomb2(bomb2),
        .wall_hit(wall_hit),
        .bombed_by_p1(bombed_by_p1),
        .bombed_by_p2(bombed_by_p2),
        .shoe_hit(shoe_hit),
        .shoe_held(shoe_held),
        .shoe_idx(shoe_idx),
        .box_idx(box_idx),
        .bg_idx(bg_idx),
        .stage(stage)
    );

    layer_compositor layer_compositor_inst (
        .Clk(Clk),
        .rst_n(rst_n),
        .stage(stage),
        .vga_color(vga_color),
        .vga_valid(vga_valid)
    );

endmodule

`default_nettype wire

/* hdl/layer_compositor.sv */
/*
  Second pipeline stage, one cycle.
  Priority, highest first: fire, player 1, player 2, bomb 1, bomb 2,
  then the wall state, then background.
  A hit sprite whose entry is transparent shows background, never a
  lower layer. Only vga_valid is reset.
*/
`timescale 1ns/1ps
`default_nettype none

module layer_compositor (
    input  logic                     Clk,
    input  logic                     rst_n,
    input  color_mapper_pkg::stage_t stage,
    output color_mapper_pkg::rgb_t   vga_color,
    output logic                     vga_valid
);

    import color_mapper_pkg::*;

    rgb_t next_color;

    // sprite color, or background where it is see-through
    function automatic rgb_t sprite_or_bg(input layer_t sprite, input rgb_t bg);
        if (sprite.opaque)
        begin
            return sprite.color;
        end
        return bg;
    endfunction

    // ----------------------------------------
    // priority select
    // ----------------------------------------
    always_comb
    begin
        if (stage.fire)
        begin
            next_color = rgb_t'(FIRE_COLOR);
        end
        else if (stage.p1.hit)
        begin
            next_color = sprite_or_bg(stage.p1, stage.bg.color);
        end
        else if (stage.p2.hit)
        begin
            next_color = sprite_or_bg(stage.p2, stage.bg.color);
        end
        else if (stage.b1.hit)
        begin
            next_color = sprite_or_bg(stage.b1, stage.bg.color);
        end
        else if (stage.b2.hit)
        begin
            next_color = sprite_or_bg(stage.b2, stage.bg.color);
        end
        else
        begin
            case (stage.wall)
                WALL_BOX:  next_color = stage.box.color;
                WALL_SHOE: next_color = sprite_or_bg(stage.shoe, stage.bg.color);
                // opened wall or empty floor
                default:   next_color = stage.bg.color;
            endcase
        end
    end

    // ----------------------------------------
    // output register
    // ----------------------------------------
    always_ff @(posedge Clk)
    begin
        vga_color <= next_color;
        if (!rst_n)
        begin
            vga_valid <= 1'b0;
        end
        else
        begin
            vga_valid <= stage.valid;
        end
    end

endmodule

`default_nettype wire

/* hdl/palette_lookup.sv */
/*
  Combinational lookup of one index in the palette chosen by PAL.
  opaque is low on the palette's key color or when force_clear is set.
  Box and background palettes have no key, so only force_clear clears them.
*/
`timescale 1ns/1ps
`default_nettype none

module palette_lookup #(
    parameter color_mapper_pkg::pal_sel_t PAL = color_mapper_pkg::PAL_BACKGROUND
) (
    input  logic                         hit,
    input  color_mapper_pkg::color_idx_t idx,
    input  logic                         force_clear,
    output color_mapper_pkg::layer_t     layer
);

    import color_mapper_pkg::*;

    color_u      entry;
    logic [23:0] key;
    logic        keyed;

    always_comb
    begin
        keyed = 1'b1;
        key   = TRANSPARENT_MAGENTA;
        case (PAL)
            PAL_PLAYER1: entry.raw = PLAYER1_PAL[idx];
            PAL_PLAYER2: entry.raw = PLAYER2_PAL[idx];
            PAL_SHOE:    entry.raw = SHOE_PAL[idx];
            PAL_BOMB1:
            begin
                entry.raw = BOMB1_PAL[idx];
                key       = TRANSPARENT_BLACK;
            end
            PAL_BOMB2:
            begin
                entry.raw = BOMB2_PAL[idx];
                key       = TRANSPARENT_BLACK;
            end
            PAL_BOX:
            begin
                entry.raw = BOX_PAL[idx];
                keyed     = 1'b0;
            end
            default:
            begin
                entry.raw = BACKGROUND_PAL[idx];
                keyed     = 1'b0;
            end
        endcase
    end

    assign layer = '{
        hit:    hit,
        opaque: !force_clear && !(keyed && (entry.raw == key)),
        color:  entry.rgb
    };

endmodule

`default_nettype wire

/* hdl/sprite_stage.sv */
/*
  First pipeline stage, one cycle.
  Picks each player's frame by facing and looks up every layer color.
  A dead player is looked up with opaque forced low, so it shows background.
  Only the valid bit is reset; payload flows through with valid low.
*/
`timescale 1ns/1ps
`default_nettype none

module sprite_stage #(
    parameter int NUM_WALLS = 12,
    parameter int SHOE_WALL = 0
) (
    input  logic                         Clk,
    input  logic                         rst_n,
    input  logic                         pixel_valid,
    input  logic                         fire,
    input  color_mapper_pkg::player_px_t player1,
    input  color_mapper_pkg::player_px_t player2,
    input  color_mapper_pkg::bomb_px_t   bomb1,
    input  color_mapper_pkg::bomb_px_t   bomb2,
    input  logic [NUM_WALLS-1:0]         wall_hit,
    input  logic [NUM_WALLS-1:0]         bombed_by_p1,
    input  logic [NUM_WALLS-1:0]         bombed_by_p2,
    input  logic                         shoe_hit,
    input  logic [1:0]                   shoe_held,
    input  color_mapper_pkg::color_idx_t shoe_idx,
    input  color_mapper_pkg::color_idx_t box_idx,
    input  color_mapper_pkg::color_idx_t bg_idx,
    output color_mapper_pkg::stage_t     stage
);

    import color_mapper_pkg::*;

    color_idx_t  p1_idx;
    color_idx_t  p2_idx;
    layer_t      p1_layer;
    layer_t      p2_layer;
    layer_t      b1_layer;
    layer_t      b2_layer;
    layer_t      shoe_layer;
    layer_t      box_layer;
    layer_t      bg_layer;
    wall_state_t wall_state;
    stage_t      next_stage;

    function automatic color_idx_t frame_idx(input player_px_t p);
        case (p.facing)
            FACE_LEFT:  return p.idx_left;
            FACE_RIGHT: return p.idx_right;
            FACE_DOWN:  return p.idx_down;
            default:    return p.idx_forward;
        endcase
    endfunction

    assign p1_idx = frame_idx(player1);
    assign p2_idx = frame_idx(player2);

    // ----------------------------------------
    // layer lookups
    // ----------------------------------------
    palette_lookup #(.PAL(PAL_PLAYER1)) p1_lookup (
        .hit(player1.hit), .idx(p1_idx), .force_clear(player1.dead), .layer(p1_layer)
    );

    palette_lookup #(.PAL(PAL_PLAYER2)) p2_lookup (
        .hit(player2.hit), .idx(p2_idx), .force_clear(player2.dead), .layer(p2_layer)
    );

    palette_lookup #(.PAL(PAL_BOMB1)) b1_lookup (
        .hit(bomb1.hit), .idx(bomb1.idx), .force_clear(1'b0), .layer(b1_layer)
    );

    palette_lookup #(.PAL(PAL_BOMB2)) b2_lookup (
        .hit(bomb2.hit), .idx(bomb2.idx), .force_clear(1'b0), .layer(b2_layer)
    );

    palette_lookup #(.PAL(PAL_SHOE)) shoe_lookup (
        .hit(shoe_hit), .idx(shoe_idx), .force_clear(1'b0), .layer(shoe_layer)
    );

    palette_lookup #(.PAL(PAL_BOX)) box_lookup (
        .hit(|wall_hit), .idx(box_idx), .force_clear(1'b0), .layer(box_layer)
    );

    // background sits under everything
    palette_lookup #(.PAL(PAL_BACKGROUND)) bg_lookup (
        .hit(1'b1), .idx(bg_idx), .force_clear(1'b0), .layer(bg_layer)
    );

    wall_resolver #(
        .NUM_WALLS(NUM_WALLS),
        .SHOE_WALL(SHOE_WALL)
    ) wall_resolver_inst (
        .wall_hit(wall_hit),
        .bombed_by_p1(bombed_by_p1),
        .bombed_by_p2(bombed_by_p2),
        .shoe_hit(shoe_hit),
        .shoe_held(shoe_held),
        .state(wall_state)
    );

    // ----------------------------------------
    // stage register
    // ----------------------------------------
    always_comb
    begin
        next_stage.valid = pixel_valid;
        next_stage.fire  = fire;
        next_stage.p1    = p1_layer;
        next_stage.p2    = p2_layer;
        next_stage.b1    = b1_layer;
        next_stage.b2    = b2_layer;
        next_stage.wall  = wall_state;
        next_stage.box   = box_layer;
        next_stage.shoe  = shoe_layer;
        next_stage.bg    = bg_layer;
    end

    always_ff @(posedge Clk)
    begin
        stage <= next_stage;
        if (!rst_n)
        begin
            stage.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/wall_resolver.sv */
/*
  Reduces the destructible walls at one pixel to a single wall state.
  Walls are assumed not to overlap; if they do, the lowest index wins.
  The shoe is drawn only on wall SHOE_WALL, after it is bombed open,
  and only while neither player holds it.
*/
`timescale 1ns/1ps
`default_nettype none

module wall_resolver #(
    parameter int NUM_WALLS = 12,
    parameter int SHOE_WALL = 0
) (
    input  logic [NUM_WALLS-1:0]          wall_hit,
    input  logic [NUM_WALLS-1:0]          bombed_by_p1,
    input  logic [NUM_WALLS-1:0]          bombed_by_p2,
    input  logic                          shoe_hit,
    input  logic [1:0]                    shoe_held,
    output color_mapper_pkg::wall_state_t state
);

    import color_mapper_pkg::*;

    logic [NUM_WALLS-1:0] bombed;
    logic                 shoe_free;

    // either player's bomb opens a wall
    assign bombed    = bombed_by_p1 | bombed_by_p2;
    assign shoe_free = shoe_hit && (shoe_held == 2'b00);

    // scan high to low so the lowest hit wall is written last
    always_comb
    begin
        state = WALL_NONE;
        for (int i = NUM_WALLS - 1; i >= 0; i--)
        begin
            if (wall_hit[i])
            begin
                if (!bombed[i])
                begin
                    state = WALL_BOX;
                end
                else if ((i == SHOE_WALL) && shoe_free)
                begin
                    state = WALL_SHOE;
                end
                else
                begin
                    state = WALL_OPEN;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
hdl/color_mapper_pkg.sv
hdl/palette_lookup.sv
hdl/wall_resolver.sv
hdl/sprite_stage.sv
hdl/layer_compositor.sv
hdl/color_mapper_top.sv
dv/color_mapper_checker.sv
dv/color_mapper_tb.sv
